// File: common/hba_pkg.sv
/*
 * HBA serial bridge shared definitions
 * Bus widths, UART bit timing, reply characters and the
 * peripheral address map used by every block of the bridge
 */
package hba_pkg;

   // HBA bus geometry
   localparam int DBUS_WIDTH        = 8;
   localparam int PERIPH_ADDR_WIDTH = 4;
   localparam int REG_ADDR_WIDTH    = 8;
   localparam int ADDR_WIDTH        = PERIPH_ADDR_WIDTH + REG_ADDR_WIDTH; // 12

   // Serial bit time in hba_clk cycles
   localparam int CLKS_PER_BIT = 16;

   // Cycles of select with no xferack before the master gives up
   localparam int HBA_TIMEOUT = 16;

   // Reply characters
   localparam logic [7:0] ACK_CHAR  = 8'hAC; // Write fully completed
   localparam logic [7:0] NACK_CHAR = 8'h56; // Transfer timed out

   // Peripheral address map
   localparam logic [PERIPH_ADDR_WIDTH-1:0] REGFILE_PERIPH = 4'h1;
   localparam int REGFILE_DEPTH = 16;        // Byte registers in the regfile

endpackage

// File: rtl/uart/uart_rx.sv
/*
 * UART receiver, 8N1, LSB first
 * Synchronizes rxd, confirms the start bit at half a bit time,
 * then samples each data bit and the stop bit at its centre
 */
module uart_rx (
   input  logic       hba_clk,
   input  logic       hba_reset,
   input  logic       rxd,
   output logic [7:0] rx_data,
   output logic       rx_valid
);
   import hba_pkg::*;

   localparam int CW = $clog2(CLKS_PER_BIT);

   typedef enum logic [1:0] {
      RX_IDLE,
      RX_START,
      RX_DATA,
      RX_STOP
   } rx_state_t;

   rx_state_t      state;
   logic [1:0]     sync;      // Two-flop synchronizer
   logic           rxd_s;
   logic [CW-1:0]  clk_cnt;   // Cycles within the current bit
   logic [2:0]     bit_cnt;   // Data bit index

   assign rxd_s = sync[1];

   always_ff @(posedge hba_clk) begin
      if (hba_reset) begin
         sync     <= 2'b11;             // Line idles high
         state    <= RX_IDLE;
         clk_cnt  <= '0;
         bit_cnt  <= '0;
         rx_valid <= 1'b0;
      end else begin
         sync     <= {sync[0], rxd};
         rx_valid <= 1'b0;
         clk_cnt  <= clk_cnt + 1'b1;
         case (state)
            RX_IDLE: begin
               clk_cnt <= '0;
               if (!rxd_s)
                  state <= RX_START;    // Falling edge, maybe a start bit
            end
            RX_START: begin
               if (clk_cnt == CW'(CLKS_PER_BIT / 2 - 1)) begin
                  clk_cnt <= '0;
                  bit_cnt <= '0;
                  state   <= rxd_s ? RX_IDLE : RX_DATA; // Glitch rejected
               end
            end
            RX_DATA: begin
               if (clk_cnt == CW'(CLKS_PER_BIT - 1)) begin // Bit centre
                  clk_cnt <= '0;
                  bit_cnt <= bit_cnt + 1'b1;
                  if (bit_cnt == 3'd7)
                     state <= RX_STOP;
               end
            end
            default: begin              // RX_STOP
               if (clk_cnt == CW'(CLKS_PER_BIT - 1)) begin
                  rx_valid <= rxd_s;    // Framing error drops the byte
                  state    <= RX_IDLE;
               end
            end
         endcase
      end
   end

   // Data shift register, LSB arrives first
   always_ff @(posedge hba_clk) begin
      if (state == RX_DATA && clk_cnt == CW'(CLKS_PER_BIT - 1))
         rx_data <= {rxd_s, rx_data[7:1]};
   end

endmodule

// File: rtl/uart/uart_tx.sv
/*
 * UART transmitter, 8N1, LSB first
 * Shifts out start bit, eight data bits and stop bit, each held
 * for one bit time, and flags busy for the whole frame
 */
module uart_tx (
   input  logic       hba_clk,
   input  logic       hba_reset,
   input  logic       tx_start,
   input  logic [7:0] tx_data,
   output logic       txd,
   output logic       tx_busy
);
   import hba_pkg::*;

   localparam int CW = $clog2(CLKS_PER_BIT);

   logic [9:0]    shreg;     // {stop, data, start}
   logic [CW-1:0] clk_cnt;   // Cycles within the current bit
   logic [3:0]    bit_cnt;   // Frame bit index 0..9

   assign txd = shreg[0];    // Ones shift in, so idle is high

   always_ff @(posedge hba_clk) begin
      if (hba_reset) begin
         shreg   <= '1;
         clk_cnt <= '0;
         bit_cnt <= '0;
         tx_busy <= 1'b0;
      end else if (!tx_busy) begin
         clk_cnt <= '0;
         bit_cnt <= '0;
         if (tx_start) begin
            shreg   <= {1'b1, tx_data, 1'b0};
            tx_busy <= 1'b1;
         end
      end else if (clk_cnt == CW'(CLKS_PER_BIT - 1)) begin
         // End of one bit time
         clk_cnt <= '0;
         shreg   <= {1'b1, shreg[9:1]};
         if (bit_cnt == 4'd9)
            tx_busy <= 1'b0;        // Stop bit done
         else
            bit_cnt <= bit_cnt + 1'b1;
      end else begin
         clk_cnt <= clk_cnt + 1'b1;
      end
   end

endmodule

// File: rtl/serial_ctrl.sv
/*
 * Serial command controller
 * Parses command and register address bytes from the UART, runs
 * one HBA transfer per data byte and sends the reply bytes back
 */
module serial_ctrl (
   input  logic                                  hba_clk,
   input  logic                                  hba_reset,
   input  logic [7:0]                            rx_data,
   input  logic                                  rx_valid,
   output logic [7:0]                            tx_data,
   output logic                                  tx_start,
   input  logic                                  tx_busy,
   output logic [hba_pkg::PERIPH_ADDR_WIDTH-1:0] app_core_addr,
   output logic [hba_pkg::REG_ADDR_WIDTH-1:0]    app_reg_addr,
   output logic                                  app_rnw,
   output logic [hba_pkg::DBUS_WIDTH-1:0]        app_wdata,
   output logic                                  app_start,
   input  logic [hba_pkg::DBUS_WIDTH-1:0]        app_rdata,
   input  logic                                  app_done,
   input  logic                                  app_error
);
   import hba_pkg::*;

   typedef enum logic [2:0] {
      S_CMD,      // Wait for command byte
      S_REG,      // Wait for register address byte
      S_WDATA,    // Wait for next write data byte
      S_BUS,      // Bus transfer in flight
      S_RSEND,    // Read byte ready for the transmitter
      S_ACK       // Write reply
   } ctrl_state_t;

   ctrl_state_t state;
   logic [2:0]  remaining;   // Bytes left after the current one
   logic        fail;        // Sticky error over a write burst

   always_ff @(posedge hba_clk) begin
      if (hba_reset) begin
         state     <= S_CMD;
         remaining <= '0;
         fail      <= 1'b0;
         tx_start  <= 1'b0;
         app_start <= 1'b0;
      end else begin
         tx_start  <= 1'b0;      // Strobes last one cycle
         app_start <= 1'b0;
         case (state)
            S_CMD: begin
               if (rx_valid) begin
                  remaining <= rx_data[6:4];   // Count minus one
                  state     <= S_REG;
               end
            end
            S_REG: begin
               fail <= 1'b0;
               if (rx_valid) begin
                  if (app_rnw) begin
                     app_start <= 1'b1;        // Reads go straight to the bus
                     state     <= S_BUS;
                  end else begin
                     state <= S_WDATA;
                  end
               end
            end
            S_WDATA: begin
               if (rx_valid) begin
                  app_start <= 1'b1;
                  state     <= S_BUS;
               end
            end
            S_BUS: begin
               if (app_done) begin
                  if (app_rnw) begin
                     state <= S_RSEND;
                  end else begin
                     fail <= fail | app_error;
                     if (remaining == 3'd0) begin
                        state <= S_ACK;
                     end else begin
                        remaining <= remaining - 1'b1;
                        state     <= S_WDATA;
                     end
                  end
               end
            end
            S_RSEND: begin
               if (!tx_busy) begin           // Hold byte under back-pressure
                  tx_start <= 1'b1;
                  if (remaining == 3'd0) begin
                     state <= S_CMD;
                  end else begin
                     remaining <= remaining - 1'b1;
                     app_start <= 1'b1;      // Next read, address already bumped
                     state     <= S_BUS;
                  end
               end
            end
            default: begin                   // S_ACK
               if (!tx_busy) begin
                  tx_start <= 1'b1;
                  state    <= S_CMD;
               end
            end
         endcase
      end
   end

   // Request and reply payload
   always_ff @(posedge hba_clk) begin
      if (state == S_CMD && rx_valid) begin
         app_rnw       <= rx_data[7];
         app_core_addr <= rx_data[PERIPH_ADDR_WIDTH-1:0];
      end
      if (state == S_REG && rx_valid)
         app_reg_addr <= rx_data;
      else if (state == S_BUS && app_done)
         app_reg_addr <= app_reg_addr + 1'b1;  // Wraps within 8 bits
      if (state == S_WDATA && rx_valid)
         app_wdata <= rx_data;
      if (state == S_BUS && app_done && app_rnw)
         tx_data <= app_error ? NACK_CHAR : app_rdata;  // Timed out reads return NACK
      else if (state == S_ACK)
         tx_data <= fail ? NACK_CHAR : ACK_CHAR;
   end

endmodule

// File: rtl/hba_master.sv
/*
 * HBA bus master
 * Runs one bus transfer per app_start and reports done, with
 * error set when no peripheral answers within HBA_TIMEOUT cycles
 */
module hba_master (
   input  logic                                  hba_clk,
   input  logic                                  hba_reset,
   input  logic [hba_pkg::PERIPH_ADDR_WIDTH-1:0] app_core_addr,
   input  logic [hba_pkg::REG_ADDR_WIDTH-1:0]    app_reg_addr,
   input  logic                                  app_rnw,
   input  logic [hba_pkg::DBUS_WIDTH-1:0]        app_wdata,
   input  logic                                  app_start,
   output logic [hba_pkg::DBUS_WIDTH-1:0]        app_rdata,
   output logic                                  app_done,
   output logic                                  app_error,
   input  logic                                  hba_xferack,
   input  logic [hba_pkg::DBUS_WIDTH-1:0]        hba_dbus,
   output logic [hba_pkg::ADDR_WIDTH-1:0]        master_abus,
   output logic                                  master_rnw,
   output logic                                  master_select,
   output logic [hba_pkg::DBUS_WIDTH-1:0]        master_dbus
);
   import hba_pkg::*;

   localparam int TW = $clog2(HBA_TIMEOUT + 1);

   logic [ADDR_WIDTH-1:0] addr_q;    // {peripheral, register}
   logic [DBUS_WIDTH-1:0] wdata_q;
   logic                  rnw_q;
   logic [TW-1:0]         tmo_cnt;   // Cycles of select without ack

   // Bus is zero whenever no transfer is running
   assign master_abus = master_select ? addr_q : '0;
   assign master_dbus = master_select ? wdata_q : '0;
   assign master_rnw  = master_select & rnw_q;

   // Request latch and read capture
   always_ff @(posedge hba_clk) begin
      if (app_start && !master_select) begin
         addr_q  <= {app_core_addr, app_reg_addr};
         wdata_q <= app_wdata;
         rnw_q   <= app_rnw;
      end
      if (master_select && hba_xferack)
         app_rdata <= hba_dbus;
   end

   always_ff @(posedge hba_clk) begin
      if (hba_reset) begin
         master_select <= 1'b0;
         app_done      <= 1'b0;
         app_error     <= 1'b0;
         tmo_cnt       <= '0;
      end else begin
         app_done <= 1'b0;
         if (!master_select) begin
            tmo_cnt <= '0;
            if (app_start)
               master_select <= 1'b1;
         end else if (hba_xferack) begin
            master_select <= 1'b0;       // Peripheral answered
            app_done      <= 1'b1;
            app_error     <= 1'b0;
         end else if (tmo_cnt == TW'(HBA_TIMEOUT)) begin
            master_select <= 1'b0;       // Nobody home, give up
            app_done      <= 1'b1;
            app_error     <= 1'b1;
         end else begin
            tmo_cnt <= tmo_cnt + 1'b1;
         end
      end
   end

endmodule

// File: rtl/hba_regfile.sv
/*
 * HBA register file peripheral
 * Sixteen byte registers at REGFILE_PERIPH, acknowledged one
 * cycle after select, with higher register addresses aliasing
 */
module hba_regfile (
   input  logic                           hba_clk,
   input  logic                           hba_reset,
   input  logic [hba_pkg::ADDR_WIDTH-1:0] master_abus,
   input  logic                           master_rnw,
   input  logic                           master_select,
   input  logic [hba_pkg::DBUS_WIDTH-1:0] master_dbus,
   output logic                           hba_xferack,
   output logic [hba_pkg::DBUS_WIDTH-1:0] hba_dbus
);
   import hba_pkg::*;

   localparam int IW = $clog2(REGFILE_DEPTH);

   logic [DBUS_WIDTH-1:0] regs [REGFILE_DEPTH];
   logic                  hit;    // Selected with our peripheral address
   logic [IW-1:0]         idx;

   assign hit = master_select &&
                master_abus[ADDR_WIDTH-1:REG_ADDR_WIDTH] == REGFILE_PERIPH;
   assign idx = master_abus[IW-1:0];   // Low register bits only

   always_ff @(posedge hba_clk) begin
      if (hba_reset) begin
         hba_xferack <= 1'b0;
         hba_dbus    <= '0;
         for (int i = 0; i < REGFILE_DEPTH; i++)
            regs[i] <= '0;
      end else begin
         // Single-cycle ack per select
         hba_xferack <= hit && !hba_xferack;
         // Read data only alongside the ack, zero otherwise
         hba_dbus    <= (hit && !hba_xferack && master_rnw) ? regs[idx] : '0;
         if (hit && hba_xferack && !master_rnw)
            regs[idx] <= master_dbus;  // Write lands on the ack cycle
      end
   end

endmodule

// File: rtl/serial_hba_top.sv
/*
 * Serial to HBA bridge top level
 * UART pair, command controller, bus master and one
 * register file peripheral on the HBA bus
 */
module serial_hba_top (
   input  logic hba_clk,
   input  logic hba_reset,
   input  logic rxd,
   output logic txd
);
   import hba_pkg::*;

   // UART side
   logic [7:0] rx_data;
   logic       rx_valid;
   logic [7:0] tx_data;
   logic       tx_start;
   logic       tx_busy;

   // Controller to master
   logic [PERIPH_ADDR_WIDTH-1:0] app_core_addr;
   logic [REG_ADDR_WIDTH-1:0]    app_reg_addr;
   logic                         app_rnw;
   logic [DBUS_WIDTH-1:0]        app_wdata;
   logic                         app_start;
   logic [DBUS_WIDTH-1:0]        app_rdata;
   logic                         app_done;
   logic                         app_error;

   // HBA bus
   logic [ADDR_WIDTH-1:0] master_abus;
   logic                  master_rnw;
   logic                  master_select;
   logic [DBUS_WIDTH-1:0] master_dbus;
   logic                  hba_xferack;
   logic [DBUS_WIDTH-1:0] hba_dbus;

   uart_rx u_uart_rx (
      .hba_clk   (hba_clk),
      .hba_reset (hba_reset),
      .rxd       (rxd),
      .rx_data   (rx_data),
      .rx_valid  (rx_valid)
   );

   uart_tx u_uart_tx (
      .hba_clk   (hba_clk),
      .hba_reset (hba_reset),
      .tx_start  (tx_start),
      .tx_data   (tx_data),
      .txd       (txd),
      .tx_busy   (tx_busy)
   );

   serial_ctrl u_serial_ctrl (
      .hba_clk       (hba_clk),
      .hba_reset     (hba_reset),
      .rx_data       (rx_data),
      .rx_valid      (rx_valid),
      .tx_data       (tx_data),
      .tx_start      (tx_start),
      .tx_busy       (tx_busy),
      .app_core_addr (app_core_addr),
      .app_reg_addr  (app_reg_addr),
      .app_rnw       (app_rnw),
      .app_wdata     (app_wdata),
      .app_start     (app_start),
      .app_rdata     (app_rdata),
      .app_done      (app_done),
      .app_error     (app_error)
   );

   hba_master u_hba_master (
      .hba_clk       (hba_clk),
      .hba_reset     (hba_reset),
      .app_core_addr (app_core_addr),
      .app_reg_addr  (app_reg_addr),
      .app_rnw       (app_rnw),
      .app_wdata     (app_wdata),
      .app_start     (app_start),
      .app_rdata     (app_rdata),
      .app_done      (app_done),
      .app_error     (app_error),
      .hba_xferack   (hba_xferack),
      .hba_dbus      (hba_dbus),
      .master_abus   (master_abus),
      .master_rnw    (master_rnw),
      .master_select (master_select),
      .master_dbus   (master_dbus)
   );

   // Only peripheral, so its ack and read data drive the bus directly
   hba_regfile u_hba_regfile (
      .hba_clk       (hba_clk),
      .hba_reset     (hba_reset),
      .master_abus   (master_abus),
      .master_rnw    (master_rnw),
      .master_select (master_select),
      .master_dbus   (master_dbus),
      .hba_xferack   (hba_xferack),
      .hba_dbus      (hba_dbus)
   );

endmodule

// File: bench/tb_serial_hba.sv
/*
 * Serial HBA bridge testbench
 * Plays the host on rxd and txd, keeps a reference model of the
 * register file and checks every reply byte against it
 */
module tb_serial_hba;
   timeunit 1ns;
   timeprecision 100ps;
   import hba_pkg::*;

   typedef logic [7:0] byte_q_t [$];

   localparam int RX_TIMEOUT = 12 * 10 * CLKS_PER_BIT;  // Longest command plus reply
   localparam logic [PERIPH_ADDR_WIDTH-1:0] UNMAPPED = 4'h3;

   logic hba_clk;
   logic hba_reset;
   logic rxd;
   logic txd;

   logic [7:0]                   model [REGFILE_DEPTH];  // Expected regfile contents
   logic [31:0]                  rng;
   logic [7:0]                   cmd;
   logic [7:0]                   reg_addr;
   logic [PERIPH_ADDR_WIDTH-1:0] periph;
   byte_q_t                      wdata;

   serial_hba_top UUT (
      .hba_clk   (hba_clk),
      .hba_reset (hba_reset),
      .rxd       (rxd),
      .txd       (txd)
   );

   always #50 hba_clk = ~hba_clk;  // 100 ns period

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // Reply bytes of one command, model updated for mapped writes
   function automatic byte_q_t expected_reply(input logic [7:0] c, input logic [7:0] r,
                                              input byte_q_t d);
      byte_q_t    reply;
      int         n;
      logic       mapped;
      logic [3:0] idx;
      n      = int'(c[6:4]) + 1;                 // Count field is count minus one
      mapped = (c[3:0] == REGFILE_PERIPH);
      for (int k = 0; k < n; k++) begin
         idx = 4'(r + k);                        // Register wraps, low bits alias
         if (c[7])
            reply.push_back(mapped ? model[idx] : NACK_CHAR);
         else if (mapped)
            model[idx] = d[k];
      end
      if (!c[7])
         reply.push_back(mapped ? ACK_CHAR : NACK_CHAR);  // One status byte per write
      return reply;
   endfunction

   task automatic compare_value(input string name, input logic [7:0] got,
                                input logic [7:0] exp);
      if (got !== exp) begin
         $display("[FAIL] %0t ns %s got %02h expected %02h", $time, name, got, exp);
         $display("Simulation failed");
         $fatal(1);
      end
   endtask

   // One 8N1 frame on rxd, LSB first
   task automatic send_byte(input logic [7:0] b);
      logic [9:0] frame;
      frame = {1'b1, b, 1'b0};
      for (int i = 0; i < 10; i++) begin
         @(posedge hba_clk);
         #1 rxd = frame[i];
         repeat (CLKS_PER_BIT - 1) @(posedge hba_clk);
      end
   endtask

   // Sampled on the falling clock edge, where txd is stable
   task automatic recv_byte(output logic [7:0] b);
      int waited;
      waited = 0;
      @(negedge hba_clk);
      while (txd !== 1'b0) begin                 // Hunt for the start bit
         if (waited == RX_TIMEOUT) begin
            $display("No start bit on txd within %0d clock cycles", RX_TIMEOUT);
            $display("Simulation failed");
            $fatal(1);
         end
         waited++;
         @(negedge hba_clk);
      end
      repeat (CLKS_PER_BIT / 2) @(negedge hba_clk);  // Middle of start bit
      compare_value("txd start bit", 8'(txd), 8'h00);
      for (int i = 0; i < 8; i++) begin
         repeat (CLKS_PER_BIT) @(negedge hba_clk);
         b[i] = txd;
      end
      repeat (CLKS_PER_BIT) @(negedge hba_clk);
      compare_value("txd stop bit", 8'(txd), 8'h01);
   endtask

   task automatic verify_idle(input int bits);
      repeat (bits * CLKS_PER_BIT) begin
         @(negedge hba_clk);
         compare_value("txd idle", 8'(txd), 8'h01);
      end
   endtask

   task automatic send_command(input logic [7:0] c, input logic [7:0] r, input byte_q_t d);
      send_byte(c);
      send_byte(r);
      if (!c[7])
         foreach (d[k])
            send_byte(d[k]);
   endtask

   // Compares each reply byte as it arrives
   task automatic collect_reply(input byte_q_t exp);
      logic [7:0] b;
      foreach (exp[k]) begin
         recv_byte(b);
         compare_value($sformatf("txd reply byte %0d", k), b, exp[k]);
      end
   endtask

   task automatic run_command(input logic [7:0] c, input logic [7:0] r, input byte_q_t d);
      byte_q_t exp;
      exp = expected_reply(c, r, d);
      fork
         send_command(c, r, d);
         collect_reply(exp);                     // Reply may start mid command
      join
      verify_idle(2);                            // No stray bytes
   endtask

   initial begin
      hba_clk   = 1'b0;
      hba_reset = 1'b1;
      rxd       = 1'b1;                          // Line idle
      rng       = 32'h445c9783;
      for (int i = 0; i < REGFILE_DEPTH; i++)
         model[i] = '0;
      repeat (8) @(posedge hba_clk);
      #1 hba_reset = 1'b0;

      // Quiet line, then registers read back as zero
      verify_idle(20);
      wdata.delete();
      run_command({1'b1, 3'd7, REGFILE_PERIPH}, 8'h00, wdata);

      // Single byte write and read back
      wdata.delete();
      wdata.push_back(8'h3C);
      run_command({1'b0, 3'd0, REGFILE_PERIPH}, 8'h05, wdata);
      wdata.delete();
      run_command({1'b1, 3'd0, REGFILE_PERIPH}, 8'h05, wdata);

      // Burst across the top of the regfile, wraps to register 0
      wdata.delete();
      for (int k = 0; k < 8; k++)
         wdata.push_back(8'hA0 ^ 8'(k * 17));
      run_command({1'b0, 3'd7, REGFILE_PERIPH}, 8'h0C, wdata);
      wdata.delete();
      run_command({1'b1, 3'd7, REGFILE_PERIPH}, 8'h0C, wdata);
      run_command({1'b1, 3'd7, REGFILE_PERIPH}, 8'hFC, wdata);  // 8 bit wrap

      // Unmapped peripheral times out on every transfer
      wdata.delete();
      wdata.push_back(8'h5A);
      run_command({1'b0, 3'd0, UNMAPPED}, 8'h02, wdata);
      wdata.delete();
      run_command({1'b1, 3'd2, UNMAPPED}, 8'h02, wdata);
      run_command({1'b1, 3'd7, REGFILE_PERIPH}, 8'h00, wdata);  // Regfile untouched
      run_command({1'b1, 3'd7, REGFILE_PERIPH}, 8'h08, wdata);

      // Random commands
      for (int t = 0; t < 30; t++) begin
         rng      = xorshift32(rng);
         periph   = (rng[6:4] == 3'd0) ? UNMAPPED : REGFILE_PERIPH;  // About one in eight
         cmd      = {rng[0], rng[3:1], periph};
         reg_addr = rng[15:8];
         wdata.delete();
         if (!cmd[7])
            for (int k = 0; k <= int'(cmd[6:4]); k++) begin
               rng = xorshift32(rng);
               wdata.push_back(rng[7:0]);
            end
         run_command(cmd, reg_addr, wdata);
      end

      $display("Simulation completed successfully");
      $finish;
   end

endmodule

// File: all.f
common/hba_pkg.sv
rtl/uart/uart_rx.sv
rtl/uart/uart_tx.sv
rtl/serial_ctrl.sv
rtl/hba_master.sv
rtl/hba_regfile.sv
rtl/serial_hba_top.sv
bench/tb_serial_hba.sv

// File: run.sh
#!/bin/sh
# Build the serial HBA bridge testbench with Verilator and run it.
# Exit status is zero only when the pass message shows up.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps \
   --top-module tb_serial_hba -f all.f \
   --Mdir obj_dir -o tb_serial_hba || { echo "Build failed"; exit 1; }

out=$(./obj_dir/tb_serial_hba 2>&1)
echo "$out"
echo "$out" | grep -q "Simulation completed successfully" && exit 0 || exit 1
